//--- pred_macros.svh
// predictor sizing: table depths, offset and address widths
`ifndef PRED_MACROS_SVH
`define PRED_MACROS_SVH

`define PRED_ADDR_W 32     // byte address width
`define PRED_WADDR_W 30    // word address width, byte bits 31..2

`define PRED_BTB_SIZE 16   // branch target entries, power of two
`define PRED_BHT_SIZE 64   // two-bit history counters, power of two
`define PRED_JTB_SIZE 8    // jump target entries, power of two

`define PRED_BOFF_W 12     // stored branch offset, half-words
`define PRED_JOFF_W 20     // stored jump offset, half-words

`endif

//--- pred_addr_pkg.sv
// predictor address types: byte and word addresses, offsets, table tags and indices
`include "pred_macros.svh"

package pred_addr_pkg;

   typedef logic [`PRED_ADDR_W-1:0] addr_t;         // byte address
   typedef logic [`PRED_WADDR_W-1:0] word_add_t;    // word address

   typedef logic signed [`PRED_JOFF_W-1:0] joff_t;  // jump offset in half-words
   typedef logic signed [`PRED_BOFF_W-1:0] boff_t;  // branch offset in half-words

   // direct-mapped tables split the word address into index and tag
   typedef logic [$clog2(`PRED_BTB_SIZE)-1:0] btb_idx_t;
   typedef logic [`PRED_WADDR_W-$clog2(`PRED_BTB_SIZE)-1:0] btb_tag_t;
   typedef logic [$clog2(`PRED_BHT_SIZE)-1:0] bht_idx_t;
   typedef logic [$clog2(`PRED_JTB_SIZE)-1:0] jtb_idx_t;
   typedef logic [`PRED_WADDR_W-$clog2(`PRED_JTB_SIZE)-1:0] jtb_tag_t;

endpackage

//--- pred_table_pkg.sv
// predictor table types: history counter states, update records, lookup results

package pred_table_pkg;

   // two-bit saturating counter, msb set means predict taken
   typedef enum logic [1:0] {
      BHT_STRONG_NT = 2'b00,   // strong not-taken
      BHT_WEAK_NT   = 2'b01,   // weak not-taken, reset state
      BHT_WEAK_T    = 2'b10,   // weak taken
      BHT_STRONG_T  = 2'b11    // strong taken
   } bht_cnt_e;

   // training record, already corrected for rvi in the upper half-word
   typedef struct packed {
      pred_addr_pkg::word_add_t add;    // word the entry is stored against
      logic                     ualign; // rvc starting in upper half
      pred_addr_pkg::joff_t     offset; // half-word offset, jump width
      logic                     taken;  // branch condition resolved true
   } pred_upd_t;

   // one table's answer for the fetched word
   typedef struct packed {
      logic                 hit;        // valid entry with matching tag
      logic                 ualign;     // prediction belongs to upper half
      pred_addr_pkg::addr_t target;     // predicted target byte address
   } pred_hit_t;

endpackage

//--- branch_predictor.sv
// branch predictor: tagged target buffer qualified by a table of two-bit counters
`timescale 1ns/10ps
`include "pred_macros.svh"

module branch_predictor (
   input  logic                      s_clk_i,          // core clock
   input  logic                      rst_n_i,          // async reset, active low
   input  logic                      invalidate_i,     // drop every entry
   input  pred_addr_pkg::word_add_t  fetch_add_i,      // word being fetched
   input  pred_table_pkg::pred_upd_t upd_i,            // corrected training record
   input  logic                      btb_update_i,     // write target entry
   input  logic                      branch_update_i,  // step history counter
   output pred_table_pkg::pred_hit_t hit_o             // qualified lookup result
);

   localparam int unsigned IDX_W  = $clog2(`PRED_BTB_SIZE);  // btb index bits
   localparam int unsigned HIDX_W = $clog2(`PRED_BHT_SIZE);  // bht index bits

   logic [`PRED_BTB_SIZE-1:0] valid_q;                       // entry valid bits
   pred_addr_pkg::btb_tag_t   tag_q    [`PRED_BTB_SIZE];     // stored tags
   logic                      ualign_q [`PRED_BTB_SIZE];     // upper half-word flag
   pred_addr_pkg::boff_t      off_q    [`PRED_BTB_SIZE];     // branch offsets

   pred_table_pkg::bht_cnt_e  bht_q    [`PRED_BHT_SIZE];     // history counters
   pred_table_pkg::bht_cnt_e  cnt_cur;                       // counter being trained
   pred_table_pkg::bht_cnt_e  cnt_nxt;                       // its next state

   pred_addr_pkg::btb_idx_t   fetch_idx;
   pred_addr_pkg::btb_tag_t   fetch_tag;
   pred_addr_pkg::btb_idx_t   upd_idx;
   pred_addr_pkg::bht_idx_t   fetch_hidx;
   pred_addr_pkg::bht_idx_t   upd_hidx;

   pred_addr_pkg::boff_t      off_rd;                        // offset of looked-up entry
   pred_addr_pkg::addr_t      hit_base;                      // fetch word plus half flag
   pred_addr_pkg::addr_t      off_ext;                       // offset as byte distance
   logic                      tag_hit;
   logic                      cnt_taken;

   // low word bits index the tables, the rest is tag
   assign fetch_idx  = fetch_add_i[IDX_W-1:0];
   assign fetch_tag  = fetch_add_i[`PRED_WADDR_W-1:IDX_W];
   assign upd_idx    = upd_i.add[IDX_W-1:0];
   assign fetch_hidx = fetch_add_i[HIDX_W-1:0];
   assign upd_hidx   = upd_i.add[HIDX_W-1:0];

   // lookup
   assign tag_hit   = valid_q[fetch_idx] & (tag_q[fetch_idx] == fetch_tag);
   assign cnt_taken = bht_q[fetch_hidx][1];                 // weak or strong taken
   assign off_rd    = off_q[fetch_idx];
   assign hit_base  = {fetch_add_i, ualign_q[fetch_idx], 1'b0};
   assign off_ext   = {{(`PRED_ADDR_W-`PRED_BOFF_W-1){off_rd[`PRED_BOFF_W-1]}}, off_rd, 1'b0};

   assign hit_o.hit    = tag_hit & cnt_taken;
   assign hit_o.ualign = ualign_q[fetch_idx];
   assign hit_o.target = hit_base + off_ext;

   // saturating step toward the resolved direction
   always_comb begin
      cnt_cur = bht_q[upd_hidx];
      unique case (cnt_cur)
         pred_table_pkg::BHT_STRONG_NT:
            cnt_nxt = upd_i.taken ? pred_table_pkg::BHT_WEAK_NT : pred_table_pkg::BHT_STRONG_NT;
         pred_table_pkg::BHT_WEAK_NT:
            cnt_nxt = upd_i.taken ? pred_table_pkg::BHT_WEAK_T : pred_table_pkg::BHT_STRONG_NT;
         pred_table_pkg::BHT_WEAK_T:
            cnt_nxt = upd_i.taken ? pred_table_pkg::BHT_STRONG_T : pred_table_pkg::BHT_WEAK_NT;
         default:
            cnt_nxt = upd_i.taken ? pred_table_pkg::BHT_STRONG_T : pred_table_pkg::BHT_WEAK_T;
      endcase
   end

   // valid bits, invalidate beats a same-cycle write
   always_ff @(posedge s_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;
      end else if (btb_update_i) begin
         valid_q[upd_idx] <= 1'b1;
      end
   end

   // entry payload, meaningless until valid is set
   always_ff @(posedge s_clk_i) begin
      if (btb_update_i) begin
         tag_q[upd_idx]    <= upd_i.add[`PRED_WADDR_W-1:IDX_W];
         ualign_q[upd_idx] <= upd_i.ualign;
         off_q[upd_idx]    <= upd_i.offset[`PRED_BOFF_W-1:0];  // low 12 bits only
      end
   end

   // history counters start weak not-taken
   always_ff @(posedge s_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `PRED_BHT_SIZE; i++) begin
            bht_q[i] <= pred_table_pkg::BHT_WEAK_NT;
         end
      end else if (branch_update_i && !invalidate_i) begin
         bht_q[upd_hidx] <= cnt_nxt;
      end
   end

   // history only changes when execute trains it
   for (genvar g = 0; g < `PRED_BHT_SIZE; g++) begin : g_bht_chk
      a_bht_stable: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
         !branch_update_i |=> $stable(bht_q[g]));
   end

endmodule

//--- jump_predictor.sv
// jump predictor: tagged table of unconditional jump targets, taken on every hit
`timescale 1ns/10ps
`include "pred_macros.svh"

module jump_predictor (
   input  logic                      s_clk_i,        // core clock
   input  logic                      rst_n_i,        // async reset, active low
   input  logic                      invalidate_i,   // drop every entry
   input  pred_addr_pkg::word_add_t  fetch_add_i,    // word being fetched
   input  pred_table_pkg::pred_upd_t upd_i,          // corrected training record
   input  logic                      jump_update_i,  // write jump entry
   output pred_table_pkg::pred_hit_t hit_o           // lookup result
);

   localparam int unsigned IDX_W = $clog2(`PRED_JTB_SIZE);  // jtb index bits

   logic [`PRED_JTB_SIZE-1:0] valid_q;                      // entry valid bits
   pred_addr_pkg::jtb_tag_t   tag_q    [`PRED_JTB_SIZE];    // stored tags
   logic                      ualign_q [`PRED_JTB_SIZE];    // upper half-word flag
   pred_addr_pkg::joff_t      off_q    [`PRED_JTB_SIZE];    // jump offsets

   pred_addr_pkg::jtb_idx_t   fetch_idx;
   pred_addr_pkg::jtb_tag_t   fetch_tag;
   pred_addr_pkg::jtb_idx_t   upd_idx;
   pred_addr_pkg::joff_t      off_rd;                       // offset of looked-up entry
   pred_addr_pkg::addr_t      hit_base;                     // fetch word plus half flag
   pred_addr_pkg::addr_t      off_ext;                      // offset as byte distance

   assign fetch_idx = fetch_add_i[IDX_W-1:0];
   assign fetch_tag = fetch_add_i[`PRED_WADDR_W-1:IDX_W];
   assign upd_idx   = upd_i.add[IDX_W-1:0];

   // lookup, no direction state, a hit is a taken jump
   assign off_rd   = off_q[fetch_idx];
   assign hit_base = {fetch_add_i, ualign_q[fetch_idx], 1'b0};
   assign off_ext  = {{(`PRED_ADDR_W-`PRED_JOFF_W-1){off_rd[`PRED_JOFF_W-1]}}, off_rd, 1'b0};

   assign hit_o.hit    = valid_q[fetch_idx] & (tag_q[fetch_idx] == fetch_tag);
   assign hit_o.ualign = ualign_q[fetch_idx];
   assign hit_o.target = hit_base + off_ext;

   // valid bits, invalidate beats a same-cycle write
   always_ff @(posedge s_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;
      end else if (jump_update_i) begin
         valid_q[upd_idx] <= 1'b1;
      end
   end

   // entry payload
   always_ff @(posedge s_clk_i) begin
      if (jump_update_i) begin
         tag_q[upd_idx]    <= upd_i.add[`PRED_WADDR_W-1:IDX_W];
         ualign_q[upd_idx] <= upd_i.ualign;
         off_q[upd_idx]    <= upd_i.offset;
      end
   end

   // a flush leaves nothing to hit on in the following cycle
   a_inval_no_hit: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      invalidate_i |=> !hit_o.hit);

endmodule

//--- predictor.sv
// next-fetch predictor top: update alignment fix-up and branch/jump prediction select
`timescale 1ns/10ps
`include "pred_macros.svh"

module predictor (
   input  logic                     s_clk_i,          // core clock
   input  logic                     rst_n_i,          // async reset, active low
   input  logic                     invalidate_i,     // clear both tables
   input  pred_addr_pkg::word_add_t fetch_add_i,      // word to predict from

   input  logic                     instr_rvc_i,      // executed instr is compressed
   input  logic                     btb_update_i,     // write branch target
   input  logic                     branch_update_i,  // train branch history
   input  logic                     branch_taken_i,   // branch condition was true
   input  logic                     jump_update_i,    // write jump target
   input  pred_addr_pkg::joff_t     offset_i,         // half-word offset as encoded
   input  pred_addr_pkg::addr_t     base_add_i,       // address of executed instr

   output logic [1:0]               pred_taken_o,     // [0] aligned, [1] upper half
   output pred_addr_pkg::addr_t     pred_add_o        // predicted target
);

   pred_addr_pkg::addr_t      base_p2;      // base moved to next word
   pred_addr_pkg::addr_t      upd_add;      // corrected base address
   pred_addr_pkg::joff_t      off_m1;       // offset shortened by one half-word
   logic                      rvi_upper;    // 32-bit instr starting at bit 1
   pred_table_pkg::pred_upd_t upd;          // record for both tables

   pred_table_pkg::pred_hit_t bp_hit;
   pred_table_pkg::pred_hit_t jp_hit;
   logic                      taken_al;
   logic                      taken_ual;
   logic                      use_bp;       // branch supplies the target

   // fetch never starts mid-word, so an rvi in the upper half is predicted
   // from the following word with the offset pulled back to keep the target
   assign rvi_upper = ~instr_rvc_i & base_add_i[1];
   assign base_p2   = base_add_i + pred_addr_pkg::addr_t'(2);
   assign off_m1    = offset_i - pred_addr_pkg::joff_t'(1);
   assign upd_add   = rvi_upper ? base_p2 : base_add_i;

   assign upd.add    = upd_add[`PRED_ADDR_W-1:2];
   assign upd.ualign = instr_rvc_i & base_add_i[1];      // rvc may sit in upper half
   assign upd.offset = rvi_upper ? off_m1 : offset_i;
   assign upd.taken  = branch_taken_i;

   branch_predictor i_bp (
      .s_clk_i         (s_clk_i),
      .rst_n_i         (rst_n_i),
      .invalidate_i    (invalidate_i),
      .fetch_add_i     (fetch_add_i),
      .upd_i           (upd),
      .btb_update_i    (btb_update_i),
      .branch_update_i (branch_update_i),
      .hit_o           (bp_hit)
   );

   jump_predictor i_jp (
      .s_clk_i       (s_clk_i),
      .rst_n_i       (rst_n_i),
      .invalidate_i  (invalidate_i),
      .fetch_add_i   (fetch_add_i),
      .upd_i         (upd),
      .jump_update_i (jump_update_i),
      .hit_o         (jp_hit)
   );

   // aligned half has priority, upper half only if nothing earlier is taken
   assign taken_al  = (bp_hit.hit & ~bp_hit.ualign) | (jp_hit.hit & ~jp_hit.ualign);
   assign taken_ual = ~taken_al & ((bp_hit.hit & bp_hit.ualign) | (jp_hit.hit & jp_hit.ualign));

   // branch wins unless it is the upper one and a jump also hits
   assign use_bp = bp_hit.hit & (~bp_hit.ualign | ~jp_hit.hit);

   assign pred_taken_o = {taken_ual, taken_al};
   assign pred_add_o   = use_bp ? bp_hit.target : jp_hit.target;

   // only one redirect point per fetched word
   a_one_taken: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      !(pred_taken_o[0] && pred_taken_o[1]));

endmodule

//--- tb_predictor.sv
// predictor testbench: directed and random table training checked against a reference model
`timescale 1ns/10ps
`include "pred_macros.svh"

module tb_predictor;

   localparam int EDGE_TIMEOUT = 200;    // 1 ns polls before a clock edge counts as lost
   localparam int RUN_LIMIT    = 2000;   // clock periods for the whole run

   logic                     s_clk;
   logic                     rst_n;
   logic                     invalidate;
   pred_addr_pkg::word_add_t fetch_add;
   logic                     instr_rvc;
   logic                     btb_update;
   logic                     branch_update;
   logic                     branch_taken;
   logic                     jump_update;
   pred_addr_pkg::joff_t     offset;
   pred_addr_pkg::addr_t     base_add;
   logic [1:0]               pred_taken;
   pred_addr_pkg::addr_t     pred_add;

   int unsigned err_cnt   = 0;
   int unsigned chk_cnt   = 0;
   int unsigned test_no   = 0;
   int unsigned test_err0 = 0;           // errors before the running test
   int unsigned cyc_cnt   = 0;           // rising edges seen
   realtime     edge_time = 0.0;         // time of the last rising edge
   logic        check_en  = 1'b0;
   logic        run_done  = 1'b0;
   logic [15:0] lfsr;

   // shadow tables, indexed like the hardware, full word address kept instead of tag
   logic                     m_bvalid [`PRED_BTB_SIZE];
   pred_addr_pkg::word_add_t m_badd   [`PRED_BTB_SIZE];
   logic                     m_bual   [`PRED_BTB_SIZE];
   pred_addr_pkg::boff_t     m_boff   [`PRED_BTB_SIZE];
   int                       m_bht    [`PRED_BHT_SIZE];   // 0 strong nt .. 3 strong t
   logic                     m_jvalid [`PRED_JTB_SIZE];
   pred_addr_pkg::word_add_t m_jadd   [`PRED_JTB_SIZE];
   logic                     m_jual   [`PRED_JTB_SIZE];
   pred_addr_pkg::joff_t     m_joff   [`PRED_JTB_SIZE];

   predictor i_dut (
      .s_clk_i         (s_clk),
      .rst_n_i         (rst_n),
      .invalidate_i    (invalidate),
      .fetch_add_i     (fetch_add),
      .instr_rvc_i     (instr_rvc),
      .btb_update_i    (btb_update),
      .branch_update_i (branch_update),
      .branch_taken_i  (branch_taken),
      .jump_update_i   (jump_update),
      .offset_i        (offset),
      .base_add_i      (base_add),
      .pred_taken_o    (pred_taken),
      .pred_add_o      (pred_add)
   );

   initial begin
      s_clk = 1'b0;
      forever #50 s_clk = ~s_clk;                        // 100 ns period
   end

   always @(posedge s_clk) begin
      edge_time = $realtime;
      cyc_cnt   = cyc_cnt + 1;
   end

   // 16-bit fibonacci lfsr, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);                         // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // expected outputs for a fetched word, from the shadow tables
   function automatic void predict_ref(input pred_addr_pkg::word_add_t f,
                                       output logic [1:0] tk,
                                       output pred_addr_pkg::addr_t add);
      int                   bi;
      int                   ji;
      int                   soff;
      logic                 b_hit;
      logic                 j_hit;
      pred_addr_pkg::addr_t b_tgt;
      pred_addr_pkg::addr_t j_tgt;
      bi    = int'(f % `PRED_BTB_SIZE);
      ji    = int'(f % `PRED_JTB_SIZE);
      b_hit = m_bvalid[bi] && (m_badd[bi] == f) && (m_bht[f % `PRED_BHT_SIZE] >= 2);
      soff  = m_boff[bi];                                // sign extends
      b_tgt = {f, m_bual[bi], 1'b0} + pred_addr_pkg::addr_t'(2 * soff);
      j_hit = m_jvalid[ji] && (m_jadd[ji] == f);
      soff  = m_joff[ji];
      j_tgt = {f, m_jual[ji], 1'b0} + pred_addr_pkg::addr_t'(2 * soff);
      tk[0] = (b_hit && !m_bual[bi]) || (j_hit && !m_jual[ji]);
      tk[1] = !tk[0] && ((b_hit && m_bual[bi]) || (j_hit && m_jual[ji]));
      add   = (b_hit && (!m_bual[bi] || !j_hit)) ? b_tgt : j_tgt;   // upper branch yields
   endfunction

   task automatic drop_entries();
      for (int i = 0; i < `PRED_BTB_SIZE; i++) begin
         m_bvalid[i] = 1'b0;
      end
      for (int i = 0; i < `PRED_JTB_SIZE; i++) begin
         m_jvalid[i] = 1'b0;
      end
   endtask

   // model training, same edge as the hardware
   always @(posedge s_clk or negedge rst_n) begin : ref_update
      pred_addr_pkg::addr_t     t;
      pred_addr_pkg::addr_t     d;
      pred_addr_pkg::word_add_t w;
      logic                     u;
      int                       bi;
      int                       ji;
      int                       hi;
      if (!rst_n) begin
         drop_entries();
         for (int i = 0; i < `PRED_BHT_SIZE; i++) begin
            m_bht[i] = 1;                                // weak not-taken
         end
      end else if (invalidate) begin
         drop_entries();                                 // updates in this cycle are lost
      end else begin
         u = instr_rvc & base_add[1];
         t = base_add + pred_addr_pkg::addr_t'(2 * int'(offset));   // target of the instr
         w = base_add[31:2];
         if (!instr_rvc && base_add[1]) begin
            w = w + 1'b1;                                // rvi in upper half, next word
         end
         d  = t - {w, u, 1'b0};                          // distance from the stored half-word
         bi = int'(w % `PRED_BTB_SIZE);
         ji = int'(w % `PRED_JTB_SIZE);
         hi = int'(w % `PRED_BHT_SIZE);
         if (btb_update) begin
            m_bvalid[bi] = 1'b1;
            m_badd[bi]   = w;
            m_bual[bi]   = u;
            m_boff[bi]   = d[`PRED_BOFF_W:1];            // branch keeps low bits
         end
         if (branch_update) begin
            if (branch_taken && m_bht[hi] < 3) begin
               m_bht[hi] = m_bht[hi] + 1;
            end else if (!branch_taken && m_bht[hi] > 0) begin
               m_bht[hi] = m_bht[hi] - 1;
            end
         end
         if (jump_update) begin
            m_jvalid[ji] = 1'b1;
            m_jadd[ji]   = w;
            m_jual[ji]   = u;
            m_joff[ji]   = d[`PRED_JOFF_W:1];
         end
      end
   end

   task automatic compare_taken(input logic [1:0] got, input logic [1:0] exp,
                                input string what);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("error at %0t ns: %s, pred_taken_o %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic compare_add(input pred_addr_pkg::addr_t got,
                              input pred_addr_pkg::addr_t exp, input string what);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("error at %0t ns: %s, pred_add_o %h, expected %h", $time, what, got, exp);
      end
   endtask

   // every cycle, 10 ns before the edge, against the model
   always @(posedge s_clk) begin : compare_proc
      logic [1:0]           exp_tk;
      pred_addr_pkg::addr_t exp_add;
      #90;
      if (check_en) begin
         predict_ref(fetch_add, exp_tk, exp_add);
         compare_taken(pred_taken, exp_tk, "model");
         if (exp_tk != 2'b00) begin
            compare_add(pred_add, exp_add, "model");             // target only on a hit
         end
      end
   end

   // next rising edge, then 10 ns in
   task automatic step();
      int unsigned start;
      int unsigned guard;
      start = cyc_cnt;
      guard = 0;
      while (cyc_cnt == start && guard < EDGE_TIMEOUT) begin
         #1;
         guard++;
      end
      if (cyc_cnt == start) begin
         err_cnt++;
         $display("clock stopped: no rising edge within %0d ns", EDGE_TIMEOUT);
      end else begin
         #(edge_time + 10.0 - $realtime);
      end
   endtask

   task automatic clear_strobes();
      invalidate    = 1'b0;
      btb_update    = 1'b0;
      branch_update = 1'b0;
      jump_update   = 1'b0;
   endtask

   task automatic train(input logic jmp, input logic btb, input logic br, input logic tkn,
                        input logic rvc, input pred_addr_pkg::addr_t base,
                        input pred_addr_pkg::joff_t off);
      jump_update   = jmp;
      btb_update    = btb;
      branch_update = br;
      branch_taken  = tkn;
      instr_rvc     = rvc;
      base_add      = base;
      offset        = off;
      step();
      clear_strobes();
   endtask

   task automatic flush_tables();
      invalidate = 1'b1;
      step();
      invalidate = 1'b0;
   endtask

   // directed expectation late in the current cycle
   task automatic expect_pred(input logic [1:0] tk, input pred_addr_pkg::addr_t add,
                              input string what);
      #(edge_time + 90.0 - $realtime);
      compare_taken(pred_taken, tk, what);
      if (tk != 2'b00) begin
         compare_add(pred_add, add, what);
      end
      step();
   endtask

   task automatic start_test();
      test_no++;
      test_err0 = err_cnt;
   endtask

   task automatic end_test(input string name);
      if (err_cnt == test_err0) begin
         $display("test %0d %s: ok", test_no, name);
      end else begin
         $display("test %0d %s: %0d mismatches", test_no, name, err_cnt - test_err0);
      end
   endtask

   initial begin : watchdog
      int unsigned waited;
      waited = 0;
      while (!run_done && waited < RUN_LIMIT) begin
         #100;
         waited++;
      end
      if (!run_done) begin
         $display("run did not finish within %0d clock periods", RUN_LIMIT);
         $display("Checks failed");
         $finish;
      end
   end

   initial begin : main_seq
      logic [31:0] r;
      rst_n         = 1'b0;
      invalidate    = 1'b0;
      fetch_add     = '0;
      instr_rvc     = 1'b0;
      btb_update    = 1'b0;
      branch_update = 1'b0;
      branch_taken  = 1'b0;
      jump_update   = 1'b0;
      offset        = '0;
      base_add      = '0;
      lfsr          = 16'd52;
      repeat (3) step();                                  // reset over three edges
      rst_n    = 1'b1;
      check_en = 1'b1;

      start_test();
      for (int n = 0; n < 4; n++) begin
         fetch_add = pred_addr_pkg::word_add_t'(rand_bits(30));
         expect_pred(2'b00, '0, "empty tables");
      end
      train(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0044, 20'sd4);
      train(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 32'h0000_0044, 20'sd8);
      fetch_add = 30'h11;
      expect_pred(2'b01, 32'h0000_0044 + 32'd16, "trained word");   // branch beats jump
      flush_tables();
      expect_pred(2'b00, '0, "after invalidate");
      end_test("reset and invalidate");

      start_test();
      train(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0100, 20'sd24);
      fetch_add = 30'h40;
      expect_pred(2'b01, 32'h0000_0100 + 32'd48, "aligned jump");
      fetch_add = 30'h40 + `PRED_JTB_SIZE;                 // same slot, other tag
      expect_pred(2'b00, '0, "tag mismatch");
      end_test("aligned jump");

      start_test();
      train(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 32'h0000_0200, -20'sd8);
      fetch_add = 30'h80;
      expect_pred(2'b01, 32'h0000_0200 - 32'd16, "weak taken branch");
      train(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0000_0200, 20'sd0);
      train(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0000_0200, 20'sd0);
      expect_pred(2'b00, '0, "branch trained not-taken");
      end_test("branch history");

      start_test();
      train(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0302, 20'sd10);
      fetch_add = 30'hC1;
      expect_pred(2'b01, 32'h0000_0302 + 32'd20, "rvi jump from next word");
      fetch_add = 30'hC0;
      expect_pred(2'b00, '0, "rvi jump own word");
      end_test("rvi in upper half");

      start_test();
      train(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_0416, 20'sd6);
      fetch_add = 30'h105;
      expect_pred(2'b10, 32'h0000_0416 + 32'd12, "rvc jump upper half");
      train(1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 32'h0000_0414, 20'sd16);
      expect_pred(2'b01, 32'h0000_0414 + 32'd32, "aligned branch first");
      end_test("rvc upper half and priority");

      start_test();
      for (int n = 0; n < 200; n++) begin
         r = rand_bits(27);
         fetch_add     = pred_addr_pkg::word_add_t'(r[6:0]);   // small range, many hits
         invalidate    = (r[11:7] == 5'd0);                    // about one in 32
         btb_update    = (r[13:12] == 2'd0);
         branch_update = r[14];
         branch_taken  = r[15];
         jump_update   = (r[17:16] == 2'd0);
         instr_rvc     = r[18];
         base_add      = pred_addr_pkg::addr_t'({r[26:19], 1'b0});
         r = rand_bits(16);
         offset        = {{4{r[15]}}, r[15:0]};
         step();
      end
      clear_strobes();
      step();
      end_test("random traffic");

      run_done = 1'b1;
      $display("%0d tests, %0d checks, %0d errors", test_no, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+.
pred_addr_pkg.sv
pred_table_pkg.sv
branch_predictor.sv
jump_predictor.sv
predictor.sv
tb_predictor.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_predictor
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
